//--- design/dbg_macros.svh
`ifndef DBG_MACROS_SVH
`define DBG_MACROS_SVH

// Serial bit period in clk cycles
`define DBG_CLKS_PER_BIT 8

// Loop passes of the core program
`define DBG_LOOP_COUNT 5

// Immediate added on each pass
`define DBG_ADD_STEP 3

// ASCII "done", last word of every report
`define DBG_REPORT_TAG 32'h646f6e65

`endif

//--- design/dbg_pkg.sv
package dbg_pkg;

    // One serial data byte
    typedef logic [7:0] uart_byte_t;

    // Core state as seen by the debug unit
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] cycle_count;          // Enabled cycles before halt
        logic [31:0] acc;
        logic        halted;               // Current instruction is HALT
    } core_status_t;

    // Accumulator core instruction set
    typedef enum logic [2:0] {
        LDI_ACC = 3'd0,                    // acc <= imm
        LDI_CNT = 3'd1,                    // cnt <= imm
        ADDI    = 3'd2,                    // acc <= acc + imm
        DJNZ    = 3'd3,                    // cnt--, jump to imm if nonzero
        HALT    = 3'd4
    } core_op_e;

endpackage

//--- design/uart_rx.sv
`timescale 1ns/1ps
`include "dbg_macros.svh"

module uart_rx import dbg_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       i_rx,
    input  logic       i_rx_clear,
    output logic       o_rx_ready,
    output uart_byte_t o_rx_data
);

    localparam int CLKS  = `DBG_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CLKS);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e        state;
    logic [1:0]       rx_sync;
    logic [CNT_W-1:0] baud_cnt;
    logic [2:0]       bit_cnt;
    uart_byte_t       shift;
    logic             rx_bit;
    logic             bit_tick;

    assign rx_bit   = rx_sync[1];
    assign bit_tick = (baud_cnt == CNT_W'(CLKS - 1));   // Middle of a data or stop bit

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_sync    <= 2'b11;
            state      <= RX_IDLE;
            baud_cnt   <= '0;
            bit_cnt    <= '0;
            o_rx_ready <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], i_rx};
            if (i_rx_clear) begin
                o_rx_ready <= 1'b0;
            end
            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    if (!rx_bit) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (baud_cnt == CNT_W'(CLKS / 2 - 1)) begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_bit ? RX_IDLE : RX_DATA;   // Glitch, not a start bit
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_tick) begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_tick) begin
                        state <= RX_IDLE;
                        if (rx_bit) begin
                            o_rx_ready <= 1'b1;   // Wins over a clear in the same cycle
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_tick) begin
            shift <= {rx_bit, shift[7:1]};   // LSB first
        end
        if (state == RX_STOP && bit_tick && rx_bit) begin
            o_rx_data <= shift;
        end
    end

endmodule

//--- design/uart_tx.sv
`timescale 1ns/1ps
`include "dbg_macros.svh"

module uart_tx import dbg_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       i_tx_start,
    input  uart_byte_t i_tx_data,
    output logic       o_tx_done,
    output logic       o_tx
);

    localparam int CLKS  = `DBG_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CLKS);

    logic [CNT_W-1:0] baud_cnt;
    logic [3:0]       bit_cnt;                 // 0 start, 1..8 data, 9 stop
    logic [8:0]       frame;                   // Data bits then stop bit
    logic             bit_end;

    assign bit_end = (baud_cnt == CNT_W'(CLKS - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            o_tx_done <= 1'b1;
            o_tx      <= 1'b1;
            baud_cnt  <= '0;
            bit_cnt   <= '0;
        end else if (o_tx_done) begin
            if (i_tx_start) begin
                o_tx_done <= 1'b0;
                o_tx      <= 1'b0;             // Start bit
                baud_cnt  <= '0;
                bit_cnt   <= '0;
            end
        end else if (bit_end) begin
            baud_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                o_tx_done <= 1'b1;             // Stop bit finished
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
                o_tx    <= frame[0];
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (o_tx_done && i_tx_start) begin
            frame <= {1'b1, i_tx_data};
        end else if (!o_tx_done && bit_end) begin
            frame <= {1'b1, frame[8:1]};
        end
    end

endmodule

//--- design/acc_core.sv
`timescale 1ns/1ps
`include "dbg_macros.svh"

module acc_core import dbg_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         i_core_reset,
    input  logic         i_core_enable,
    output core_status_t o_status
);

    logic [31:0] pc;
    logic [31:0] cycle_count;
    logic [31:0] acc;
    logic [31:0] cnt;
    logic [31:0] cnt_dec;
    logic [31:0] imm;
    core_op_e    op;
    logic        halted;

    // Program ROM
    always_comb begin
        case (pc)
            32'd0: begin
                op  = LDI_ACC;
                imm = 32'd0;
            end
            32'd1: begin
                op  = LDI_CNT;
                imm = 32'(`DBG_LOOP_COUNT);
            end
            32'd2: begin
                op  = ADDI;
                imm = 32'(`DBG_ADD_STEP);
            end
            32'd3: begin
                op  = DJNZ;
                imm = 32'd2;                   // Back to the ADDI
            end
            default: begin
                op  = HALT;
                imm = 32'd0;
            end
        endcase
    end

    assign halted  = (op == HALT);
    assign cnt_dec = cnt - 32'd1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc          <= '0;
            cycle_count <= '0;
            acc         <= '0;
            cnt         <= '0;
        end else if (i_core_reset) begin
            pc          <= '0;
            cycle_count <= '0;
            acc         <= '0;
            cnt         <= '0;
        end else if (i_core_enable && !halted) begin
            cycle_count <= cycle_count + 32'd1;
            pc          <= pc + 32'd1;
            case (op)
                LDI_ACC: acc <= imm;
                LDI_CNT: cnt <= imm;
                ADDI:    acc <= acc + imm;
                DJNZ: begin
                    cnt <= cnt_dec;
                    if (cnt_dec != 32'd0) begin
                        pc <= imm;
                    end
                end
                default: pc <= pc;
            endcase
        end
    end

    assign o_status = '{pc: pc, cycle_count: cycle_count, acc: acc, halted: halted};

endmodule

//--- design/debug_unit.sv
`timescale 1ns/1ps
`include "dbg_macros.svh"

module debug_unit import dbg_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         i_rx_ready,
    input  uart_byte_t   i_rx_data,
    output logic         o_rx_clear,
    input  logic         i_tx_done,
    output logic         o_tx_start,
    output uart_byte_t   o_tx_data,
    input  core_status_t i_core_status,
    output logic         o_core_reset,
    output logic         o_core_enable
);

    localparam uart_byte_t CMD_RUN  = 8'h72;   // 'r'
    localparam uart_byte_t CMD_STEP = 8'h73;   // 's'
    localparam uart_byte_t CMD_NEXT = 8'h6e;   // 'n'

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RUN,
        ST_STEP,
        ST_PREPARE,
        ST_SEND,
        ST_WAIT
    } dbg_state_e;

    dbg_state_e  state, state_next;
    logic        rx_clear_next;
    logic        tx_start_next;
    logic        core_reset_next;
    logic        core_enable_next;
    logic        step_mode, step_mode_next;
    logic [2:0]  word_cnt, word_cnt_next;   // Report word, 4 means finished
    logic [1:0]  byte_cnt, byte_cnt_next;   // Byte within the word
    logic [31:0] word_sr, word_sr_next;

    assign o_tx_data = word_sr[31:24];      // MSB first

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state         <= ST_IDLE;
            o_rx_clear    <= 1'b0;
            o_tx_start    <= 1'b0;
            o_core_reset  <= 1'b1;
            o_core_enable <= 1'b0;
            step_mode     <= 1'b0;
            word_cnt      <= '0;
            byte_cnt      <= '0;
        end else begin
            state         <= state_next;
            o_rx_clear    <= rx_clear_next;
            o_tx_start    <= tx_start_next;
            o_core_reset  <= core_reset_next;
            o_core_enable <= core_enable_next;
            step_mode     <= step_mode_next;
            word_cnt      <= word_cnt_next;
            byte_cnt      <= byte_cnt_next;
        end
    end

    always_ff @(posedge clk) begin
        word_sr <= word_sr_next;
    end

    always_comb begin
        state_next       = state;
        rx_clear_next    = 1'b0;
        tx_start_next    = o_tx_start;
        core_reset_next  = o_core_reset;
        core_enable_next = o_core_enable;
        step_mode_next   = step_mode;
        word_cnt_next    = word_cnt;
        byte_cnt_next    = byte_cnt;
        word_sr_next     = word_sr;

        case (state)
            ST_IDLE: begin
                // Skip the byte whose clear is still in flight
                if (i_rx_ready && !o_rx_clear) begin
                    rx_clear_next = 1'b1;
                    case (i_rx_data)
                        CMD_RUN: begin
                            state_next      = ST_RUN;
                            step_mode_next  = 1'b0;
                            core_reset_next = 1'b1;
                        end
                        CMD_STEP: begin
                            state_next      = ST_STEP;
                            step_mode_next  = 1'b1;
                            core_reset_next = 1'b1;
                        end
                        default: state_next = ST_IDLE;
                    endcase
                end
            end
            ST_RUN: begin
                if (o_core_enable && i_core_status.halted) begin
                    core_enable_next = 1'b0;   // Core state stays frozen
                    state_next       = ST_PREPARE;
                end else begin
                    core_reset_next  = 1'b0;
                    core_enable_next = 1'b1;
                end
            end
            ST_STEP: begin
                core_reset_next = 1'b0;
                if (o_core_enable) begin
                    core_enable_next = 1'b0;   // Single enabled cycle
                    state_next       = ST_PREPARE;
                end else if (i_rx_ready && !o_rx_clear) begin
                    rx_clear_next = 1'b1;
                    if (i_rx_data == CMD_NEXT) begin
                        core_enable_next = 1'b1;
                    end
                end
            end
            ST_PREPARE: begin
                tx_start_next = 1'b1;
                byte_cnt_next = '0;
                word_cnt_next = word_cnt + 3'd1;
                state_next    = ST_SEND;
                case (word_cnt)
                    3'd0: word_sr_next = i_core_status.pc;
                    3'd1: word_sr_next = i_core_status.cycle_count;
                    3'd2: word_sr_next = i_core_status.acc;
                    3'd3: word_sr_next = `DBG_REPORT_TAG;
                    default: begin
                        tx_start_next = 1'b0;
                        word_cnt_next = '0;
                        if (step_mode && !i_core_status.halted) begin
                            state_next = ST_STEP;
                        end else begin
                            state_next = ST_IDLE;
                        end
                    end
                endcase
            end
            ST_SEND: begin
                if (!i_tx_done) begin
                    tx_start_next = 1'b0;   // Byte accepted
                    byte_cnt_next = byte_cnt + 2'd1;
                    state_next    = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (i_tx_done) begin
                    if (byte_cnt == 2'd0) begin
                        state_next = ST_PREPARE;   // Counter wrapped, word sent
                    end else begin
                        word_sr_next  = word_sr << 8;
                        tx_start_next = 1'b1;
                        state_next    = ST_SEND;
                    end
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

endmodule

//--- design/debug_top.sv
`timescale 1ns/1ps

module debug_top import dbg_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic i_rx,
    output logic o_tx
);

    logic         rx_ready;
    logic         rx_clear;
    uart_byte_t   rx_data;
    logic         tx_done;
    logic         tx_start;
    uart_byte_t   tx_data;
    core_status_t core_status;
    logic         core_reset;
    logic         core_enable;

    uart_rx uart_rx_i (
        .clk        (clk),
        .reset      (reset),
        .i_rx       (i_rx),
        .i_rx_clear (rx_clear),
        .o_rx_ready (rx_ready),
        .o_rx_data  (rx_data)
    );

    uart_tx uart_tx_i (
        .clk        (clk),
        .reset      (reset),
        .i_tx_start (tx_start),
        .i_tx_data  (tx_data),
        .o_tx_done  (tx_done),
        .o_tx       (o_tx)
    );

    debug_unit debug_unit_i (
        .clk           (clk),
        .reset         (reset),
        .i_rx_ready    (rx_ready),
        .i_rx_data     (rx_data),
        .o_rx_clear    (rx_clear),
        .i_tx_done     (tx_done),
        .o_tx_start    (tx_start),
        .o_tx_data     (tx_data),
        .i_core_status (core_status),
        .o_core_reset  (core_reset),
        .o_core_enable (core_enable)
    );

    acc_core acc_core_i (
        .clk           (clk),
        .reset         (reset),
        .i_core_reset  (core_reset),
        .i_core_enable (core_enable),
        .o_status      (core_status)
    );

endmodule

//--- tb/debug_top_asserts.sv
`timescale 1ns/1ps

module debug_top_asserts import dbg_pkg::*; (
    input logic         clk,
    input logic         reset,
    input logic [2:0]   i_state,
    input logic         i_step_mode,
    input logic         i_core_reset,
    input logic         i_core_enable,
    input core_status_t i_core_status,
    input uart_byte_t   i_rx_data,
    input logic         i_tx_start,
    input logic         i_tx_done
);

    localparam logic [2:0] IDLE_CODE = 3'd0;   // Idle state encoding in debug_unit
    localparam uart_byte_t CMD_NEXT  = 8'h6e;

    int assert_errors = 0;

    enable_needs_core_out_of_reset: assert property (@(posedge clk) disable iff (reset)
        !(i_core_enable && i_core_reset))
        else begin
            $error("Core enable is high while core reset is high");
            assert_errors++;
        end

    no_enable_in_idle: assert property (@(posedge clk) disable iff (reset)
        (i_state == IDLE_CODE) |-> !i_core_enable)
        else begin
            $error("Core enable is high while the debug unit is idle");
            assert_errors++;
        end

    // One enabled cycle, and only for a next command
    single_step_pulse: assert property (@(posedge clk) disable iff (reset)
        (i_step_mode && i_core_enable) |=> !i_core_enable)
        else begin
            $error("Core enable lasted more than one cycle in step mode");
            assert_errors++;
        end

    step_from_next_cmd: assert property (@(posedge clk) disable iff (reset)
        (i_step_mode && $rose(i_core_enable)) |-> ($past(i_rx_data) == CMD_NEXT))
        else begin
            $error("Step started without a next command");
            assert_errors++;
        end

    enable_drops_on_halt: assert property (@(posedge clk) disable iff (reset)
        (i_core_enable && i_core_status.halted) |=> !i_core_enable)
        else begin
            $error("Core enable stayed high after the core halted");
            assert_errors++;
        end

    start_only_when_done: assert property (@(posedge clk) disable iff (reset)
        $rose(i_tx_start) |-> i_tx_done)
        else begin
            $error("Transmit start rose while the transmitter was busy");
            assert_errors++;
        end

endmodule

//--- tb/debug_top_tb.sv
`timescale 1ns/1ps
`include "dbg_macros.svh"

module debug_top_tb import dbg_pkg::*; ();

    localparam int          CLKS          = `DBG_CLKS_PER_BIT;
    localparam int          BYTE_CYCLES   = 10 * CLKS + 3;   // Frame plus handshake gap
    localparam int          REPORT_CYCLES = 16 * BYTE_CYCLES;
    localparam int          LIMIT_CYCLES  = 30 * REPORT_CYCLES + 4000;
    localparam logic [31:0] LOOPS         = `DBG_LOOP_COUNT;
    localparam logic [31:0] ADD_IMM       = `DBG_ADD_STEP;
    localparam uart_byte_t  CMD_RUN       = 8'h72;
    localparam uart_byte_t  CMD_STEP      = 8'h73;
    localparam uart_byte_t  CMD_NEXT      = 8'h6e;

    logic        clk;
    logic        reset;
    logic        serial_in;
    logic        serial_out;
    uart_byte_t  tx_bytes[$];                // Bytes seen on o_tx
    int          error_count;
    logic [31:0] lfsr;
    logic [31:0] model_pc;                   // Program model, one instruction per step
    logic [31:0] model_cyc;
    logic [31:0] model_acc;
    logic [31:0] model_cnt;

    debug_top debug_top_i (
        .clk   (clk),
        .reset (reset),
        .i_rx  (serial_in),
        .o_tx  (serial_out)
    );

    bind debug_unit debug_top_asserts asserts_i (
        .clk           (clk),
        .reset         (reset),
        .i_state       (state),
        .i_step_mode   (step_mode),
        .i_core_reset  (o_core_reset),
        .i_core_enable (o_core_enable),
        .i_core_status (i_core_status),
        .i_rx_data     (i_rx_data),
        .i_tx_start    (o_tx_start),
        .i_tx_done     (i_tx_done)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic random_garbage(output uart_byte_t b);
        do begin
            for (int i = 0; i < 8; i++) begin
                b    = {lfsr[0], b[7:1]};
                lfsr = lfsr_next(lfsr);
            end
        end while (b == CMD_RUN || b == CMD_STEP || b == CMD_NEXT);
    endtask

    task automatic send_byte(input uart_byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            serial_in = frame[i];
            repeat (CLKS) @(negedge clk);
        end
    endtask

    // LDI_ACC, LDI_CNT, ADDI, DJNZ at pc 0..3
    task automatic model_step();
        case (model_pc)
            32'd0: model_acc = 32'd0;
            32'd1: model_cnt = LOOPS;
            32'd2: model_acc = model_acc + ADD_IMM;
            default: model_cnt = model_cnt - 32'd1;
        endcase
        if (model_pc == 32'd3 && model_cnt != 32'd0) begin
            model_pc = 32'd2;
        end else begin
            model_pc = model_pc + 32'd1;
        end
        model_cyc = model_cyc + 32'd1;
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error: report %s = %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic expect_report(input logic [31:0] pc, input logic [31:0] cyc,
                                 input logic [31:0] acc);
        logic [31:0] words [4];
        while (tx_bytes.size() < 16) @(negedge clk);
        for (int w = 0; w < 4; w++) begin
            words[w] = '0;
            for (int k = 0; k < 4; k++) begin
                words[w] = {words[w][23:0], tx_bytes.pop_front()};   // MSB first
            end
        end
        check_word("pc", words[0], pc);
        check_word("cycle_count", words[1], cyc);
        check_word("acc", words[2], acc);
        check_word("tag", words[3], `DBG_REPORT_TAG);
    endtask

    task automatic expect_halt_report();
        expect_report(32'd4, 32'd2 + 2 * LOOPS, ADD_IMM * LOOPS);
    endtask

    task automatic expect_silence(input string what);
        repeat (2 * BYTE_CYCLES) begin
            @(negedge clk);
            assert (serial_out === 1'b1) else begin
                $display("** Error: o_tx = %h, expected 1 %s", serial_out, what);
                error_count++;
            end
        end
        assert (tx_bytes.size() == 0) else begin
            $display("Unexpected serial output %s", what);
            error_count++;
        end
    endtask

    initial begin : serial_monitor
        uart_byte_t b;
        @(negedge reset);
        forever begin
            @(negedge clk);
            if (serial_out == 1'b0) begin
                repeat (CLKS / 2) @(negedge clk);   // Middle of the start bit
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS) @(negedge clk);
                    b = {serial_out, b[7:1]};
                end
                repeat (CLKS) @(negedge clk);
                assert (serial_out === 1'b1) else begin
                    $display("Framing error: stop bit of a report byte is low at %0t", $time);
                    error_count++;
                end
                tx_bytes.push_back(b);
            end
        end
    end

    initial begin : watchdog
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("Timeout: the test did not finish within %0d clock cycles", LIMIT_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        uart_byte_t garbage;
        int         assert_fails;
        clk         = 1'b0;
        reset       = 1'b1;
        serial_in   = 1'b1;
        error_count = 0;
        lfsr        = 32'hd90428ed;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        expect_silence("after reset");

        send_byte(CMD_RUN);
        expect_halt_report();

        send_byte(CMD_STEP);
        model_pc  = 32'd0;
        model_cyc = 32'd0;
        model_acc = 32'd0;
        model_cnt = 32'd0;
        do begin
            send_byte(CMD_NEXT);
            model_step();
            if (model_pc == 32'd4) begin
                expect_halt_report();
            end else begin
                expect_report(model_pc, model_cyc, model_acc);
            end
        end while (model_pc != 32'd4);
        send_byte(CMD_NEXT);
        expect_silence("after a step past HALT");

        for (int i = 0; i < 6; i++) begin   // Back to back, no gap
            random_garbage(garbage);
            send_byte(garbage);
        end
        expect_silence("after non-command bytes");
        send_byte(CMD_RUN);
        expect_halt_report();
        expect_silence("after the last report");

        assert_fails = debug_top_i.debug_unit_i.asserts_i.assert_errors;
        $display("Check errors: %0d, assertion errors: %0d", error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- debug_top.f
+incdir+design
design/dbg_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/acc_core.sv
design/debug_unit.sv
design/debug_top.sv
tb/debug_top_asserts.sv
tb/debug_top_tb.sv

//--- Makefile
TB_TOP = debug_top_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f debug_top.f --top-module debug_top
	verilator --lint-only --timing --assert -f debug_top.f --top-module $(TB_TOP)

sim:
	verilator --binary --assert -f debug_top.f --top-module $(TB_TOP)
	-obj_dir/V$(TB_TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
